// File: Makefile
TOP = late_exec_tb

.PHONY: sim clean

# Build and run; the run passes only if the pass line shows up in the output.
sim:
	verilator --binary --timing -f build.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir

// File: build.f
src/mips_pkg.sv
src/writeback_if.sv
src/alu.sv
src/delay_fu.sv
src/reg_file.sv
src/hilo_cp0_regs.sv
src/late_exec_top.sv
verification/late_exec_checker.sv
verification/late_exec_tb.sv

// File: src/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::word_t    a,
    input  mips_pkg::word_t    b,
    input  mips_pkg::alufunc_t func,
    output mips_pkg::word_t    result,
    output logic               overflow
);
    import mips_pkg::*;

    word_t sum;
    word_t diff;
    logic  add_ovf;
    logic  sub_ovf;

    assign sum  = a + b;
    assign diff = a - b;

    // Signed overflow: operands of equal sign giving a result of the other sign.
    assign add_ovf = (a[31] == b[31]) && (sum[31] != a[31]);
    // Subtraction flips the sign test on b.
    assign sub_ovf = (a[31] != b[31]) && (diff[31] != a[31]);

    always_comb
    begin
        result = '0;
        case (func)
            ALU_ADD:   result = sum;
            ALU_SUB:   result = diff;
            ALU_AND:   result = a & b;
            ALU_OR:    result = a | b;
            ALU_XOR:   result = a ^ b;
            ALU_NOR:   result = ~(a | b);
            ALU_SLT:   result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:  result = {31'b0, a < b};
            ALU_SLL:   result = b << a[4:0];        // Shift amount arrives on a.
            ALU_SRL:   result = b >> a[4:0];
            ALU_SRA:   result = $signed(b) >>> a[4:0];
            ALU_LUI:   result = {b[15:0], 16'b0};
            ALU_PASSA: result = a;
            ALU_PASSB: result = b;
            default:   result = '0;
        endcase
    end

    // Only the trapping add and subtract report overflow.
    always_comb
    begin
        case (func)
            ALU_ADD: overflow = add_ovf;
            ALU_SUB: overflow = sub_ovf;
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: src/delay_fu.sv
`timescale 1ns/1ps
`default_nettype none

module delay_fu #(
    parameter int CP0_REGS = 8
) (
    input  logic                                            issue_valid,
    input  mips_pkg::exec_data_t                            issue,
    output mips_pkg::reg_addr_t                             rega_addr,
    output mips_pkg::reg_addr_t                             regb_addr,
    input  mips_pkg::word_t                                 rega_data,
    input  mips_pkg::word_t                                 regb_data,
    input  mips_pkg::word_t                                 hi_data,
    input  mips_pkg::word_t                                 lo_data,
    input  mips_pkg::word_t                                 cp0_data,
    output logic [mips_pkg::cp0_addr_bits(CP0_REGS)-1:0]    cp0_addr,
    output logic                                            wb_valid,
    output logic                                            reg_we,
    output mips_pkg::reg_addr_t                             reg_dest,
    output mips_pkg::word_t                                 result,
    output logic                                            hi_we,
    output logic                                            lo_we,
    output logic                                            cp0_we,
    output mips_pkg::word_t                                 cp0_wdata,
    output logic                                            overflow
);
    import mips_pkg::*;

    localparam int CP0_AW = cp0_addr_bits(CP0_REGS);

    alufunc_t func;
    alusrc_t  alusrc;
    logic     shamt_valid;
    logic     hitoreg;
    logic     lotoreg;
    logic     cp0toreg;
    logic     regwrite;
    logic     hiwrite;
    logic     lowrite;
    logic     cp0write;
    logic     ovf_check;
    logic     link;
    word_t    srca;
    word_t    srcb;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    word_t    pcplus8;
    logic     alu_overflow;
    logic     write_cond;

    // Control table: ALU function, operand-B source and write enables per op.
    always_comb
    begin
        func        = ALU_PASSA;
        alusrc      = REGB;
        shamt_valid = 1'b0;
        hitoreg     = 1'b0;
        lotoreg     = 1'b0;
        cp0toreg    = 1'b0;
        regwrite    = 1'b0;
        hiwrite     = 1'b0;
        lowrite     = 1'b0;
        cp0write    = 1'b0;
        ovf_check   = 1'b0;
        link        = 1'b0;
        case (issue.op)
            OP_ADD:   begin func = ALU_ADD;  regwrite = 1'b1; ovf_check = 1'b1; end
            OP_ADDU:  begin func = ALU_ADD;  regwrite = 1'b1; end
            OP_SUB:   begin func = ALU_SUB;  regwrite = 1'b1; ovf_check = 1'b1; end
            OP_SUBU:  begin func = ALU_SUB;  regwrite = 1'b1; end
            OP_AND:   begin func = ALU_AND;  regwrite = 1'b1; end
            OP_OR:    begin func = ALU_OR;   regwrite = 1'b1; end
            OP_XOR:   begin func = ALU_XOR;  regwrite = 1'b1; end
            OP_NOR:   begin func = ALU_NOR;  regwrite = 1'b1; end
            OP_SLT:   begin func = ALU_SLT;  regwrite = 1'b1; end
            OP_SLTU:  begin func = ALU_SLTU; regwrite = 1'b1; end
            OP_SLL:   begin func = ALU_SLL;  regwrite = 1'b1; shamt_valid = 1'b1; end
            OP_SRL:   begin func = ALU_SRL;  regwrite = 1'b1; shamt_valid = 1'b1; end
            OP_SRA:   begin func = ALU_SRA;  regwrite = 1'b1; shamt_valid = 1'b1; end
            OP_ADDI:  begin func = ALU_ADD;  alusrc = IMM; regwrite = 1'b1; ovf_check = 1'b1; end
            OP_ADDIU: begin func = ALU_ADD;  alusrc = IMM; regwrite = 1'b1; end
            OP_ORI:   begin func = ALU_OR;   alusrc = IMM; regwrite = 1'b1; end
            OP_LUI:   begin func = ALU_LUI;  alusrc = IMM; regwrite = 1'b1; end
            OP_MOVZ,
            OP_MOVN:  func = ALU_PASSA;      // Write decided below from operand B.
            OP_MFHI:  begin hitoreg = 1'b1;  regwrite = 1'b1; end
            OP_MFLO:  begin func = ALU_PASSB; lotoreg = 1'b1; regwrite = 1'b1; end
            OP_MTHI:  hiwrite = 1'b1;
            OP_MTLO:  lowrite = 1'b1;
            OP_MFC0:  begin cp0toreg = 1'b1; regwrite = 1'b1; end
            OP_MTC0:  begin func = ALU_PASSB; cp0write = 1'b1; end
            OP_LINK:  begin regwrite = 1'b1; link = 1'b1; end
            default:  func = ALU_PASSA;
        endcase
    end

    assign rega_addr = issue.srcrega;
    assign regb_addr = issue.srcregb;
    assign cp0_addr  = issue.srcrega[CP0_AW-1:0];

    // Late operand resolution; a bypassed value wins over any stored one.
    assign srca = (issue.readya) ? (issue.srca) : (
                  (hitoreg)      ? (hi_data)    : (
                  (cp0toreg)     ? (cp0_data)   : (rega_data)));
    assign srcb = (issue.readyb) ? (issue.srcb) : (
                  (lotoreg)      ? (lo_data)    : (regb_data));

    assign alu_a = (shamt_valid)     ? ({27'b0, issue.shamt}) : (srca);
    assign alu_b = (alusrc == REGB)  ? (srcb)                 : (issue.extended_imm);

    alu i_alu (
        .a        (alu_a),
        .b        (alu_b),
        .func     (func),
        .result   (alu_result),
        .overflow (alu_overflow)
    );

    assign pcplus8 = issue.pcplus4 + 32'd4;

    // Conditional moves test operand B.
    assign write_cond = (issue.op == OP_MOVZ) ? (alu_b == '0) : (
                        (issue.op == OP_MOVN) ? (alu_b != '0) : (regwrite));

    assign wb_valid  = issue_valid;
    assign overflow  = issue_valid && ovf_check && alu_overflow;
    assign reg_we    = issue_valid && write_cond && !overflow && (issue.destreg != '0);
    assign reg_dest  = issue.destreg;
    assign result    = (link) ? (pcplus8) : (alu_result);
    assign hi_we     = issue_valid && hiwrite;
    assign lo_we     = issue_valid && lowrite;
    assign cp0_we    = issue_valid && cp0write;
    assign cp0_wdata = alu_b;

endmodule

`default_nettype wire

// File: src/hilo_cp0_regs.sv
`timescale 1ns/1ps
`default_nettype none

module hilo_cp0_regs #(
    parameter int CP0_REGS = 8
) (
    input  logic                                         clk,
    input  logic                                         reset,
    writeback_if.hilo                                    wb,
    input  logic [mips_pkg::cp0_addr_bits(CP0_REGS)-1:0] cp0_addr,
    output mips_pkg::word_t                              hi_data,
    output mips_pkg::word_t                              lo_data,
    output mips_pkg::word_t                              cp0_data
);
    import mips_pkg::*;

    localparam int CP0_AW = cp0_addr_bits(CP0_REGS);

    word_t hi_q;
    word_t lo_q;
    word_t cp0_bank [CP0_REGS];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hi_q <= '0;
            lo_q <= '0;
            for (int i = 0; i < CP0_REGS; i++)
            begin
                cp0_bank[i] <= '0;
            end
        end
        else
        begin
            if (wb.hi_we)
                hi_q <= wb.hi_data;
            if (wb.lo_we)
                lo_q <= wb.lo_data;
            if (wb.cp0_we && (int'(wb.cp0_addr[CP0_AW-1:0]) < CP0_REGS))
                cp0_bank[wb.cp0_addr[CP0_AW-1:0]] <= wb.cp0_data; // Index wraps on low bits.
        end
    end

    assign hi_data = hi_q;
    assign lo_data = lo_q;

    // A single-entry bank still has a one-bit index, so guard the upper half.
    assign cp0_data = (int'(cp0_addr) < CP0_REGS) ? cp0_bank[cp0_addr] : '0;

endmodule

`default_nettype wire

// File: src/late_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module late_exec_top #(
    parameter int CP0_REGS = 8
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_valid,
    input  mips_pkg::decoded_op_t  in_op,
    input  mips_pkg::reg_addr_t    in_srcrega,
    input  mips_pkg::reg_addr_t    in_srcregb,
    input  mips_pkg::reg_addr_t    in_destreg,
    input  logic [4:0]             in_shamt,
    input  mips_pkg::word_t        in_imm,
    input  mips_pkg::word_t        in_srca,
    input  logic                   in_readya,
    input  mips_pkg::word_t        in_srcb,
    input  logic                   in_readyb,
    input  mips_pkg::word_t        in_pcplus4,
    output logic                   out_valid,
    output logic                   out_we,
    output mips_pkg::reg_addr_t    out_dest,
    output mips_pkg::word_t        out_result,
    output logic                   out_overflow
);
    import mips_pkg::*;

    localparam int CP0_AW = cp0_addr_bits(CP0_REGS);

    logic              issue_valid;
    exec_data_t        issue_q;
    reg_addr_t         rega_addr;
    reg_addr_t         regb_addr;
    word_t             rega_data;
    word_t             regb_data;
    word_t             hi_data;
    word_t             lo_data;
    word_t             cp0_data;
    logic [CP0_AW-1:0] cp0_addr;
    logic              fu_valid;
    logic              fu_reg_we;
    reg_addr_t         fu_dest;
    word_t             fu_result;
    logic              fu_hi_we;
    logic              fu_lo_we;
    logic              fu_cp0_we;
    word_t             fu_cp0_wdata;
    logic              fu_overflow;

    writeback_if wb_bus ();

    // Issue register.
    always_ff @(posedge clk)
    begin
        if (reset)
            issue_valid <= 1'b0;
        else
            issue_valid <= in_valid;
        issue_q.op           <= in_op;
        issue_q.srcrega      <= in_srcrega;
        issue_q.srcregb      <= in_srcregb;
        issue_q.destreg      <= in_destreg;
        issue_q.shamt        <= in_shamt;
        issue_q.extended_imm <= in_imm;
        issue_q.srca         <= in_srca;
        issue_q.readya       <= in_readya;
        issue_q.srcb         <= in_srcb;
        issue_q.readyb       <= in_readyb;
        issue_q.pcplus4      <= in_pcplus4;
    end

    reg_file i_reg_file (
        .clk       (clk),
        .reset     (reset),
        .wb        (wb_bus.regs),
        .rega_addr (rega_addr),
        .regb_addr (regb_addr),
        .rega_data (rega_data),
        .regb_data (regb_data)
    );

    hilo_cp0_regs #(.CP0_REGS(CP0_REGS)) i_hilo_cp0_regs (
        .clk      (clk),
        .reset    (reset),
        .wb       (wb_bus.hilo),
        .cp0_addr (cp0_addr),
        .hi_data  (hi_data),
        .lo_data  (lo_data),
        .cp0_data (cp0_data)
    );

    delay_fu #(.CP0_REGS(CP0_REGS)) i_delay_fu (
        .issue_valid (issue_valid),
        .issue       (issue_q),
        .rega_addr   (rega_addr),
        .regb_addr   (regb_addr),
        .rega_data   (rega_data),
        .regb_data   (regb_data),
        .hi_data     (hi_data),
        .lo_data     (lo_data),
        .cp0_data    (cp0_data),
        .cp0_addr    (cp0_addr),
        .wb_valid    (fu_valid),
        .reg_we      (fu_reg_we),
        .reg_dest    (fu_dest),
        .result      (fu_result),
        .hi_we       (fu_hi_we),
        .lo_we       (fu_lo_we),
        .cp0_we      (fu_cp0_we),
        .cp0_wdata   (fu_cp0_wdata),
        .overflow    (fu_overflow)
    );

    // Commit register for the out ports.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            out_valid    <= 1'b0;
            out_we       <= 1'b0;
            out_overflow <= 1'b0;
        end
        else
        begin
            out_valid    <= fu_valid;
            out_we       <= fu_reg_we;
            out_overflow <= fu_overflow;
        end
        out_dest   <= fu_dest;
        out_result <= fu_result;
    end

    // The storage blocks take these on the same edge as the commit register.
    assign wb_bus.reg_we   = fu_reg_we;
    assign wb_bus.reg_addr = fu_dest;
    assign wb_bus.reg_data = fu_result;
    assign wb_bus.hi_we    = fu_hi_we;
    assign wb_bus.hi_data  = fu_result;      // MTHI and MTLO pass operand A through.
    assign wb_bus.lo_we    = fu_lo_we;
    assign wb_bus.lo_data  = fu_result;
    assign wb_bus.cp0_we   = fu_cp0_we;
    assign wb_bus.cp0_addr = issue_q.srcrega;
    assign wb_bus.cp0_data = fu_cp0_wdata;

endmodule

`default_nettype wire

// File: src/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Operations handled by the late-execute unit.
    typedef enum logic [4:0] {
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADDI,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_MOVZ,
        OP_MOVN,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO,
        OP_MFC0,
        OP_MTC0,
        OP_LINK
    } decoded_op_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI,
        ALU_PASSA, ALU_PASSB // Route one operand straight to the result.
    } alufunc_t;

    typedef enum logic {
        REGB,
        IMM
    } alusrc_t;

    // One instruction as handed over by the issuer.
    typedef struct packed {
        decoded_op_t op;
        reg_addr_t   srcrega;      // Also the CP0 index for MFC0 and MTC0.
        reg_addr_t   srcregb;
        reg_addr_t   destreg;
        logic [4:0]  shamt;
        word_t       extended_imm;
        word_t       srca;         // Bypassed value, valid when readya is set.
        logic        readya;
        word_t       srcb;
        logic        readyb;
        word_t       pcplus4;
    } exec_data_t;

    // Index width of a CP0 bank with the given number of registers.
    function automatic int cp0_addr_bits(input int regs);
        return (regs > 1) ? $clog2(regs) : 1;
    endfunction

endpackage

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                clk,
    input  logic                reset,
    writeback_if.regs           wb,
    input  mips_pkg::reg_addr_t rega_addr,
    input  mips_pkg::reg_addr_t regb_addr,
    output mips_pkg::word_t     rega_data,
    output mips_pkg::word_t     regb_data
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wb.reg_we && (wb.reg_addr != '0))
        begin
            regs[wb.reg_addr] <= wb.reg_data; // Register 0 is never written.
        end
    end

    // Asynchronous reads.
    assign rega_data = (rega_addr == '0) ? '0 : regs[rega_addr];
    assign regb_data = (regb_addr == '0) ? '0 : regs[regb_addr];

endmodule

`default_nettype wire

// File: src/writeback_if.sv
`timescale 1ns/1ps
`default_nettype none

interface writeback_if;
    import mips_pkg::*;

    logic      reg_we;
    reg_addr_t reg_addr;
    word_t     reg_data;
    logic      hi_we;
    word_t     hi_data;
    logic      lo_we;
    word_t     lo_data;
    logic      cp0_we;
    reg_addr_t cp0_addr; // Full index; the CP0 bank uses the low bits.
    word_t     cp0_data;

    modport commit (
        output reg_we, reg_addr, reg_data,
        output hi_we, hi_data, lo_we, lo_data,
        output cp0_we, cp0_addr, cp0_data
    );

    modport regs (input reg_we, reg_addr, reg_data);

    modport hilo (
        input hi_we, hi_data, lo_we, lo_data,
        input cp0_we, cp0_addr, cp0_data
    );

endinterface

`default_nettype wire

// File: verification/late_exec_checker.sv
`timescale 1ns/1ps
`default_nettype none

module late_exec_checker #(
    parameter int CP0_REGS = 8
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_valid,
    input mips_pkg::decoded_op_t in_op,
    input mips_pkg::reg_addr_t   in_srcrega,
    input mips_pkg::reg_addr_t   in_srcregb,
    input mips_pkg::reg_addr_t   in_destreg,
    input logic [4:0]            in_shamt,
    input mips_pkg::word_t       in_imm,
    input mips_pkg::word_t       in_srca,
    input logic                  in_readya,
    input mips_pkg::word_t       in_srcb,
    input logic                  in_readyb,
    input mips_pkg::word_t       in_pcplus4,
    input logic                  out_valid,
    input logic                  out_we,
    input mips_pkg::reg_addr_t   out_dest,
    input mips_pkg::word_t       out_result,
    input logic                  out_overflow
);
    import mips_pkg::*;

    // Expected outcome of one instruction, including the side writes.
    typedef struct packed {
        logic      valid;
        logic      we;
        reg_addr_t dest;
        word_t     result;
        logic      ovf;
        logic      hi_we;
        logic      lo_we;
        logic      cp0_we;
        reg_addr_t cp0_idx;
        word_t     wdata;
    } outcome_t;

    word_t      regs [32];
    word_t      cp0 [32];    // Only the low CP0_REGS entries are used.
    word_t      hi;
    word_t      lo;
    exec_data_t held;        // Sampled at issue and resolved one cycle later.
    logic       held_valid;
    outcome_t   pending;     // Resolved and waiting for the commit outputs.
    string      test_name = "none";
    int         tests;
    int         checks;
    int         errors;
    int         test_checks;
    int         test_errors;

    function automatic outcome_t predict(input exec_data_t x);
        outcome_t    o;
        word_t       a;
        word_t       b;
        logic [32:0] wide;
        o         = '0;
        o.valid   = 1'b1;
        o.we      = 1'b1;
        o.dest    = x.destreg;
        o.cp0_idx = x.srcrega & reg_addr_t'(CP0_REGS - 1);
        if (x.readya)
            a = x.srca;
        else if (x.op == OP_MFHI)
            a = hi;
        else if (x.op == OP_MFC0)
            a = cp0[o.cp0_idx];
        else
            a = regs[x.srcrega];
        if (x.readyb)
            b = x.srcb;
        else if (x.op == OP_MFLO)
            b = lo;
        else
            b = regs[x.srcregb];
        if (x.op inside {OP_SLL, OP_SRL, OP_SRA})
            a = {27'b0, x.shamt};
        if (x.op inside {OP_ADDI, OP_ADDIU, OP_ORI, OP_LUI})
            b = x.extended_imm;
        case (x.op)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU:
            begin
                // A doubled sign bit that disagrees marks overflow.
                wide     = {a[31], a} + {b[31], b};
                o.result = wide[31:0];
                o.ovf    = (x.op inside {OP_ADD, OP_ADDI}) && (wide[32] != wide[31]);
            end
            OP_SUB, OP_SUBU:
            begin
                wide     = {a[31], a} - {b[31], b};
                o.result = wide[31:0];
                o.ovf    = (x.op == OP_SUB) && (wide[32] != wide[31]);
            end
            OP_AND:        o.result = a & b;
            OP_OR, OP_ORI: o.result = a | b;
            OP_XOR:        o.result = a ^ b;
            OP_NOR:        o.result = ~(a | b);
            OP_SLT:        o.result = {31'b0, ($signed(a) < $signed(b))};
            OP_SLTU:       o.result = {31'b0, (a < b)};
            OP_SLL:        o.result = b << a[4:0];
            OP_SRL:        o.result = b >> a[4:0];
            OP_SRA:        o.result = $signed(b) >>> a[4:0];
            OP_LUI:        o.result = {b[15:0], 16'h0000};
            OP_MOVZ:
            begin
                o.result = a;
                o.we     = (b == '0);
            end
            OP_MOVN:
            begin
                o.result = a;
                o.we     = (b != '0);
            end
            OP_MFHI, OP_MFC0: o.result = a;
            OP_MFLO:          o.result = b;
            OP_MTHI:
            begin
                o.we    = 1'b0;
                o.hi_we = 1'b1;
                o.wdata = a;
            end
            OP_MTLO:
            begin
                o.we    = 1'b0;
                o.lo_we = 1'b1;
                o.wdata = a;
            end
            OP_MTC0:
            begin
                o.we     = 1'b0;
                o.cp0_we = 1'b1;
                o.wdata  = b;
            end
            OP_LINK: o.result = x.pcplus4 + 32'd4;
            default: o.we = 1'b0;
        endcase
        if (o.ovf || (x.destreg == '0))
            o.we = 1'b0; // Trapped or aimed at register 0.
        return o;
    endfunction

    task automatic check_value(input string what, input word_t expected, input word_t actual);
        checks++;
        test_checks++;
        if (actual !== expected)
        begin
            errors++;
            test_errors++;
            $display("[ERROR] %s: %s expected 0x%08h, actual 0x%08h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic compare(input outcome_t e);
        check_value("out_valid", word_t'(e.valid), word_t'(out_valid));
        check_value("out_we", word_t'(e.we), word_t'(out_we));
        check_value("out_overflow", word_t'(e.ovf), word_t'(out_overflow));
        if (e.we)
        begin
            check_value("out_dest", word_t'(e.dest), word_t'(out_dest));
            check_value("out_result", e.result, out_result);
        end
    endtask

    // The writes land in the storage blocks on the commit edge.
    task automatic retire(input outcome_t e);
        if (e.we)
            regs[e.dest] = e.result;
        if (e.hi_we)
            hi = e.wdata;
        if (e.lo_we)
            lo = e.wdata;
        if (e.cp0_we)
            cp0[e.cp0_idx] = e.wdata;
    endtask

    task automatic clear_model();
        for (int i = 0; i < 32; i++)
        begin
            regs[i] = '0;
            cp0[i]  = '0;
        end
        hi = '0;
        lo = '0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests++;
        $display("Test %s finished: %0d checks, %0d errors", test_name, test_checks,
                 test_errors);
    endtask

    task automatic report();
        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    endtask

    // Inputs and outputs are both settled at the falling edge.
    always @(negedge clk)
    begin
        outcome_t fresh;
        fresh = '0;
        if (reset)
        begin
            clear_model();
            held_valid = 1'b0;
            pending    = '0;
        end
        else
        begin
            compare(pending);
            retire(pending);
            if (held_valid)
                fresh = predict(held); // Sees the writes of the edge just passed.
            pending              = fresh;
            held_valid           = in_valid;
            held.op              = in_op;
            held.srcrega         = in_srcrega;
            held.srcregb         = in_srcregb;
            held.destreg         = in_destreg;
            held.shamt           = in_shamt;
            held.extended_imm    = in_imm;
            held.srca            = in_srca;
            held.readya          = in_readya;
            held.srcb            = in_srcb;
            held.readyb          = in_readyb;
            held.pcplus4         = in_pcplus4;
        end
    end

endmodule

`default_nettype wire

// File: verification/late_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module late_exec_tb;
    import mips_pkg::*;

    localparam int CP0_REGS      = 8;
    localparam int SEED          = 9449;
    localparam int RESET_CYCLES  = 3;
    localparam int DRAIN_CYCLES  = 3;
    localparam int RANDOM_CYCLES = 300;
    // Issued instructions of each test plus its drain.
    localparam int T1_LEN        = 4 + DRAIN_CYCLES;
    localparam int T2_LEN        = 40 + DRAIN_CYCLES;
    localparam int T3_LEN        = 10 + DRAIN_CYCLES;
    localparam int T4_LEN        = 9 + DRAIN_CYCLES;
    localparam int T5_LEN        = RANDOM_CYCLES + DRAIN_CYCLES;
    localparam int CYCLE_LIMIT   = RESET_CYCLES + T1_LEN + T2_LEN + T3_LEN + T4_LEN
                                   + T5_LEN + 50;

    logic        clk;
    logic        reset;
    logic        in_valid;
    decoded_op_t in_op;
    reg_addr_t   in_srcrega;
    reg_addr_t   in_srcregb;
    reg_addr_t   in_destreg;
    logic [4:0]  in_shamt;
    word_t       in_imm;
    word_t       in_srca;
    logic        in_readya;
    word_t       in_srcb;
    logic        in_readyb;
    word_t       in_pcplus4;
    logic        out_valid;
    logic        out_we;
    reg_addr_t   out_dest;
    word_t       out_result;
    logic        out_overflow;
    word_t       pc;
    int          cycle_count;

    late_exec_top #(.CP0_REGS(CP0_REGS)) i_late_exec_top (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_op        (in_op),
        .in_srcrega   (in_srcrega),
        .in_srcregb   (in_srcregb),
        .in_destreg   (in_destreg),
        .in_shamt     (in_shamt),
        .in_imm       (in_imm),
        .in_srca      (in_srca),
        .in_readya    (in_readya),
        .in_srcb      (in_srcb),
        .in_readyb    (in_readyb),
        .in_pcplus4   (in_pcplus4),
        .out_valid    (out_valid),
        .out_we       (out_we),
        .out_dest     (out_dest),
        .out_result   (out_result),
        .out_overflow (out_overflow)
    );

    late_exec_checker #(.CP0_REGS(CP0_REGS)) i_checker (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Issue one instruction 10 ns after the rising edge; shamt rides on the immediate.
    task automatic drive(input decoded_op_t op, input reg_addr_t rd, input reg_addr_t ra,
                         input reg_addr_t rb, input logic rya, input word_t a,
                         input logic ryb, input word_t b, input word_t imm);
        @(posedge clk);
        #10;
        in_valid   = 1'b1;
        in_op      = op;
        in_destreg = rd;
        in_srcrega = ra;
        in_srcregb = rb;
        in_readya  = rya;
        in_srca    = a;
        in_readyb  = ryb;
        in_srcb    = b;
        in_imm     = imm;
        in_shamt   = imm[4:0];
        in_pcplus4 = pc;
        pc         = pc + 32'd4;
    endtask

    task automatic bypassed(input decoded_op_t op, input reg_addr_t rd, input word_t a,
                            input word_t b, input word_t imm);
        drive(op, rd, 5'd0, 5'd0, 1'b1, a, 1'b1, b, imm);
    endtask

    // Bypass values are poisoned so that a wrong select shows up.
    task automatic from_regs(input decoded_op_t op, input reg_addr_t rd, input reg_addr_t ra,
                             input reg_addr_t rb, input word_t imm);
        drive(op, rd, ra, rb, 1'b0, 32'hdead_beef, 1'b0, 32'hdead_beef, imm);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #10;
            in_valid = 1'b0;
        end
    endtask

    function automatic word_t rand_word();
        if ($urandom_range(0, 3) == 0)
            return '0; // Zero often, for MOVZ and MOVN.
        return $urandom();
    endfunction

    task automatic random_instr();
        drive(decoded_op_t'(5'($urandom_range(0, 25))), reg_addr_t'($urandom_range(0, 7)),
              reg_addr_t'($urandom_range(0, 7)), reg_addr_t'($urandom_range(0, 7)),
              1'($urandom_range(0, 1)), rand_word(), 1'($urandom_range(0, 1)),
              rand_word(), rand_word());
        in_valid = ($urandom_range(0, 7) != 0);
    endtask

    task automatic end_test();
        idle(DRAIN_CYCLES);
        i_checker.finish_test();
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT)
        begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        void'($urandom(SEED));
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_op      = OP_ADD;
        in_srcrega = '0;
        in_srcregb = '0;
        in_destreg = '0;
        in_shamt   = '0;
        in_imm     = '0;
        in_srca    = '0;
        in_readya  = 1'b0;
        in_srcb    = '0;
        in_readyb  = 1'b0;
        in_pcplus4 = '0;
        pc         = 32'h0040_0000;
        repeat (RESET_CYCLES) @(posedge clk);
        #10;
        reset = 1'b0;

        i_checker.start_test("reset_state");
        from_regs(OP_MFHI, 5'd1, 5'd0, 5'd0, '0);
        from_regs(OP_MFLO, 5'd2, 5'd0, 5'd0, '0);
        from_regs(OP_MFC0, 5'd3, 5'd5, 5'd0, '0);
        from_regs(OP_OR, 5'd4, 5'd7, 5'd9, '0);
        end_test();

        i_checker.start_test("alu_ops");
        from_regs(OP_ADDIU, 5'd1, 5'd0, 5'd0, 32'h7fff_fff0);
        from_regs(OP_ADDIU, 5'd2, 5'd0, 5'd0, 32'h0000_0020);
        from_regs(OP_ORI, 5'd3, 5'd0, 5'd0, 32'h8000_0001);
        from_regs(OP_ADD, 5'd4, 5'd1, 5'd2, '0);                 // Positive overflow.
        from_regs(OP_SUB, 5'd5, 5'd3, 5'd2, '0);                 // Negative overflow.
        bypassed(OP_ADDI, 5'd6, 32'h7fff_ffff, '0, 32'd1);
        for (int k = 0; k <= 16; k++)
            bypassed(decoded_op_t'(5'(k)), reg_addr_t'(k + 7), $urandom(), $urandom(),
                     $urandom());
        for (int k = 0; k <= 16; k++)
            from_regs(decoded_op_t'(5'(k)), reg_addr_t'(24 + k % 8),
                      reg_addr_t'($urandom_range(1, 23)), reg_addr_t'($urandom_range(1, 23)),
                      $urandom());
        end_test();

        i_checker.start_test("cond_moves");
        bypassed(OP_MOVZ, 5'd6, 32'h1234_5678, '0, '0);
        bypassed(OP_MOVZ, 5'd7, 32'h0bad_0001, 32'd5, '0);
        bypassed(OP_MOVN, 5'd8, 32'h8765_4321, 32'd5, '0);
        bypassed(OP_MOVN, 5'd9, 32'h0bad_0002, '0, '0);
        bypassed(OP_MOVN, 5'd0, 32'hffff_ffff, 32'd1, '0);      // Dropped.
        idle(2);
        from_regs(OP_OR, 5'd10, 5'd0, 5'd0, '0);
        from_regs(OP_OR, 5'd11, 5'd6, 5'd8, '0);
        from_regs(OP_MOVZ, 5'd12, 5'd7, 5'd0, '0);
        end_test();

        i_checker.start_test("hilo_cp0_link");
        bypassed(OP_MTHI, 5'd0, 32'hcafe_0001, '0, '0);
        bypassed(OP_MTLO, 5'd0, 32'hcafe_0002, '0, '0);
        drive(OP_MTC0, 5'd0, 5'd3, 5'd0, 1'b0, '0, 1'b1, 32'hcafe_0003, '0);
        idle(2);
        from_regs(OP_MFHI, 5'd13, 5'd0, 5'd0, '0);
        from_regs(OP_MFLO, 5'd14, 5'd0, 5'd0, '0);
        from_regs(OP_MFC0, 5'd15, 5'd3, 5'd0, '0);
        from_regs(OP_LINK, 5'd31, 5'd0, 5'd0, '0);
        end_test();

        i_checker.start_test("random_deps");
        repeat (RANDOM_CYCLES) random_instr();
        end_test();

        i_checker.report();
        if (i_checker.errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire
